/* common/vc_types_pkg.sv */
package vc_types_pkg;

	// hit_way is sized for the largest legal way count (8)
	localparam int vc_max_way_bits = 3;
	localparam int vc_offset_bits = 4;

	typedef logic [15:0] vc_addr_t;
	typedef logic [11:0] vc_tag_t;
	typedef logic [127:0] vc_line_t;

	// one swap request from L2: wanted line plus the line it evicts
	typedef struct packed {
		vc_addr_t req_addr;
		vc_addr_t victim_addr;
		vc_line_t victim_data;
		logic victim_dirty;
		logic req;
	} vc_l2_req_t;

	typedef struct packed {
		logic resp;
		vc_line_t rdata;
		logic dirty;
	} vc_l2_resp_t;

	// registered result of the tag compare stage
	typedef struct packed {
		logic valid;
		logic hit;
		logic [vc_max_way_bits-1:0] hit_way;
		vc_tag_t req_tag;
		vc_tag_t victim_tag;
		vc_line_t victim_data;
		logic victim_dirty;
	} vc_lookup_t;

	// drop the byte offset, memory is line addressed
	function automatic vc_tag_t vc_addr_tag(vc_addr_t addr);
		return addr[$bits(vc_addr_t)-1:vc_offset_bits];
	endfunction

endpackage : vc_types_pkg

/* common/vc_ctrl_pkg.sv */
package vc_ctrl_pkg;

	import vc_types_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		SWAP,
		COMMIT,
		WRITEBACK,
		FETCH
	} vc_state_e;

	// strobes and entry fields from the FSM to store and datapath
	typedef struct packed {
		logic load_buffer;
		logic load_entry;
		logic sel_buffer;
		logic [vc_max_way_bits-1:0] way;
		vc_tag_t entry_tag;
		vc_line_t entry_data;
		logic entry_dirty;
	} vc_ctrl_t;

endpackage : vc_ctrl_pkg

/* src/vc_lookup.sv */
`timescale 1ns/1ps

module vc_lookup
	import vc_types_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input vc_l2_req_t l2_req,
	input vc_tag_t [num_ways-1:0] way_tags,
	input logic [num_ways-1:0] way_valid,
	output vc_lookup_t lookup
);

	vc_tag_t req_tag;
	vc_tag_t victim_tag;
	logic [num_ways-1:0] match;
	logic [vc_max_way_bits-1:0] match_way;

	logic valid_q;
	logic hit_q;
	logic [vc_max_way_bits-1:0] hit_way_q;
	vc_tag_t req_tag_q;
	vc_tag_t victim_tag_q;
	vc_line_t victim_data_q;
	logic victim_dirty_q;

	assign req_tag = vc_addr_tag(l2_req.req_addr);
	assign victim_tag = vc_addr_tag(l2_req.victim_addr);

	// associative compare against every valid way
	always_comb begin
		match = '0;
		match_way = '0;
		for (int i = 0; i < num_ways; i++) begin
			if (way_valid[i] && (way_tags[i] == req_tag)) begin
				match[i] = 1'b1;
				match_way = vc_max_way_bits'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= l2_req.req;
		end
	end

	// payload held until the next request
	always_ff @(posedge clk) begin
		if (l2_req.req) begin
			hit_q <= |match;
			hit_way_q <= match_way;
			req_tag_q <= req_tag;
			victim_tag_q <= victim_tag;
			victim_data_q <= l2_req.victim_data;
			victim_dirty_q <= l2_req.victim_dirty;
		end
	end

	assign lookup = '{
		valid: valid_q,
		hit: hit_q,
		hit_way: hit_way_q,
		req_tag: req_tag_q,
		victim_tag: victim_tag_q,
		victim_data: victim_data_q,
		victim_dirty: victim_dirty_q
	};

	// store contents must never give two matching ways
	a_single_match: assert property (@(posedge clk) disable iff (!arst_n)
		l2_req.req |-> $onehot0(match))
		else $error("vc_lookup: more than one way matches tag %h", req_tag);

endmodule : vc_lookup

/* victim_store/vc_store.sv */
`timescale 1ns/1ps

module vc_store
	import vc_types_pkg::*;
	import vc_ctrl_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input vc_ctrl_t ctrl,
	output vc_tag_t [num_ways-1:0] way_tags,
	output logic [num_ways-1:0] way_valid,
	output vc_tag_t sel_tag,
	output vc_line_t sel_data,
	output logic sel_dirty,
	output logic sel_valid
);

	localparam int way_bits = $clog2(num_ways);

	vc_tag_t [num_ways-1:0] tag_q;
	vc_line_t data_q [num_ways];
	logic [num_ways-1:0] dirty_q;
	logic [num_ways-1:0] valid_q;
	logic [way_bits-1:0] idx;
	logic dup_tag;

	assign idx = ctrl.way[way_bits-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (ctrl.load_entry) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// entry arrays, written whole line at a time
	always_ff @(posedge clk) begin
		if (ctrl.load_entry) begin
			tag_q[idx] <= ctrl.entry_tag;
			data_q[idx] <= ctrl.entry_data;
			dirty_q[idx] <= ctrl.entry_dirty;
		end
	end

	assign way_tags = tag_q;
	assign way_valid = valid_q;

	// read mux for the way the FSM is working on
	assign sel_tag = tag_q[idx];
	assign sel_data = data_q[idx];
	assign sel_dirty = dirty_q[idx];
	assign sel_valid = valid_q[idx];

	always_comb begin
		dup_tag = 1'b0;
		for (int i = 0; i < num_ways; i++) begin
			for (int j = i + 1; j < num_ways; j++) begin
				if (valid_q[i] && valid_q[j] && (tag_q[i] == tag_q[j])) begin
					dup_tag = 1'b1;
				end
			end
		end
	end

	// exclusivity with L2 keeps every cached tag unique
	a_unique_tags: assert property (@(posedge clk) disable iff (!arst_n)
		!dup_tag)
		else $error("vc_store: two valid ways hold the same tag");

endmodule : vc_store

/* victim_store/vc_lru.sv */
`timescale 1ns/1ps

module vc_lru
	import vc_types_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input logic touch,
	input logic [vc_max_way_bits-1:0] touch_way,
	output logic [vc_max_way_bits-1:0] lru_way
);

	localparam int way_bits = $clog2(num_ways);

	// age 0 is youngest, num_ways-1 is oldest
	logic [way_bits-1:0] age_q [num_ways];
	logic [way_bits-1:0] touch_age;
	logic [num_ways-1:0] rank_seen;

	assign touch_age = age_q[touch_way[way_bits-1:0]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// way 0 starts out oldest
			for (int i = 0; i < num_ways; i++) begin
				age_q[i] <= way_bits'(num_ways - 1 - i);
			end
		end else if (touch) begin
			for (int i = 0; i < num_ways; i++) begin
				if (i == int'(touch_way)) begin
					age_q[i] <= '0;
				end else if (age_q[i] < touch_age) begin
					age_q[i] <= age_q[i] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		lru_way = '0;
		rank_seen = '0;
		for (int i = 0; i < num_ways; i++) begin
			rank_seen[age_q[i]] = 1'b1;
			if (age_q[i] == way_bits'(num_ways - 1)) begin
				lru_way = vc_max_way_bits'(i);
			end
		end
	end

	a_rank_permutation: assert property (@(posedge clk) disable iff (!arst_n)
		&rank_seen)
		else $error("vc_lru: age ranks are no longer a permutation");

endmodule : vc_lru

/* src/vc_control.sv */
`timescale 1ns/1ps

module vc_control
	import vc_types_pkg::*;
	import vc_ctrl_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input vc_lookup_t lookup,
	input logic [vc_max_way_bits-1:0] lru_way,
	input logic sel_valid,
	input logic sel_dirty,
	input logic pmem_resp,
	output vc_ctrl_t ctrl,
	output logic touch,
	output logic [vc_max_way_bits-1:0] touch_way,
	output logic pmem_read,
	output logic pmem_write,
	output logic resp
);

	vc_state_e state_q;
	vc_state_e state_d;
	logic [vc_max_way_bits-1:0] way_d;
	logic [vc_max_way_bits-1:0] way_q;
	vc_tag_t entry_tag_q;
	vc_line_t entry_data_q;
	logic entry_dirty_q;
	logic load_entry;

	// hit way on a hit, otherwise replace the oldest
	assign way_d = lookup.hit ? lookup.hit_way : lru_way;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (lookup.valid) begin
					if (lookup.hit) begin
						state_d = SWAP;
					end else if (sel_valid && sel_dirty) begin
						state_d = WRITEBACK;
					end else begin
						state_d = FETCH;
					end
				end
			end
			SWAP: state_d = COMMIT;
			COMMIT: state_d = IDLE;
			WRITEBACK: begin
				if (pmem_resp) begin
					state_d = FETCH;
				end
			end
			FETCH: begin
				if (pmem_resp) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			way_q <= '0;
		end else begin
			state_q <= state_d;
			if ((state_q == IDLE) && lookup.valid) begin
				way_q <= way_d;
			end
		end
	end

	// victim held here until it is written into the way
	always_ff @(posedge clk) begin
		if ((state_q == IDLE) && lookup.valid) begin
			entry_tag_q <= lookup.victim_tag;
			entry_data_q <= lookup.victim_data;
			entry_dirty_q <= lookup.victim_dirty;
		end
	end

	assign load_entry = (state_q == COMMIT) || ((state_q == FETCH) && pmem_resp);

	// way follows the fresh lookup in idle so dirty check sees the lru way
	assign ctrl = '{
		load_buffer: state_q == SWAP,
		load_entry: load_entry,
		sel_buffer: state_q == COMMIT,
		way: (state_q == IDLE) ? way_d : way_q,
		entry_tag: entry_tag_q,
		entry_data: entry_data_q,
		entry_dirty: entry_dirty_q
	};

	assign touch = load_entry;
	assign touch_way = way_q;
	assign resp = load_entry;
	assign pmem_read = (state_q == FETCH);
	assign pmem_write = (state_q == WRITEBACK);

	a_mem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write))
		else $error("vc_control: memory read and write raised together");

	a_way_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		load_entry |-> (int'(ctrl.way) < num_ways))
		else $error("vc_control: entry load to way %0d out of range", ctrl.way);

endmodule : vc_control

/* src/vc_datapath.sv */
`timescale 1ns/1ps

module vc_datapath
	import vc_types_pkg::*;
	import vc_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input vc_ctrl_t ctrl,
	input vc_tag_t sel_tag,
	input vc_line_t sel_data,
	input logic sel_dirty,
	input vc_tag_t req_tag,
	input vc_line_t pmem_rdata,
	input logic pmem_write,
	output vc_addr_t pmem_address,
	output vc_line_t pmem_wdata,
	output vc_line_t rdata,
	output logic rdata_dirty
);

	vc_line_t buf_data;
	logic buf_dirty;

	// swap buffer keeps the hit line while the victim overwrites its way
	always_ff @(posedge clk) begin
		if (ctrl.load_buffer) begin
			buf_data <= sel_data;
			buf_dirty <= sel_dirty;
		end
	end

	// a fetched line goes back clean
	assign rdata = ctrl.sel_buffer ? buf_data : pmem_rdata;
	assign rdata_dirty = ctrl.sel_buffer & buf_dirty;

	// writeback goes to the stored tag, fetch to the requested one
	assign pmem_address = {pmem_write ? sel_tag : req_tag, {vc_offset_bits{1'b0}}};
	assign pmem_wdata = sel_data;

	a_buffer_fresh: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.sel_buffer |-> $past(ctrl.load_buffer))
		else $error("vc_datapath: buffer returned without a load the cycle before");

endmodule : vc_datapath

/* src/victim_cache.sv */
`timescale 1ns/1ps

module victim_cache
	import vc_types_pkg::*;
	import vc_ctrl_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input vc_l2_req_t l2_req,
	output vc_l2_resp_t l2_resp,
	output logic pmem_read,
	output logic pmem_write,
	output vc_addr_t pmem_address,
	output vc_line_t pmem_wdata,
	input logic pmem_resp,
	input vc_line_t pmem_rdata
);

	vc_tag_t [num_ways-1:0] way_tags;
	logic [num_ways-1:0] way_valid;
	vc_tag_t sel_tag;
	vc_line_t sel_data;
	logic sel_dirty;
	logic sel_valid;
	logic [vc_max_way_bits-1:0] lru_way;
	logic touch;
	logic [vc_max_way_bits-1:0] touch_way;
	vc_lookup_t lookup;
	vc_ctrl_t ctrl;
	logic resp;
	vc_line_t rdata;
	logic rdata_dirty;

	vc_lookup #(.num_ways(num_ways)) u_lookup (
		.clk(clk),
		.arst_n(arst_n),
		.l2_req(l2_req),
		.way_tags(way_tags),
		.way_valid(way_valid),
		.lookup(lookup)
	);

	vc_store #(.num_ways(num_ways)) u_store (
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.way_tags(way_tags),
		.way_valid(way_valid),
		.sel_tag(sel_tag),
		.sel_data(sel_data),
		.sel_dirty(sel_dirty),
		.sel_valid(sel_valid)
	);

	vc_lru #(.num_ways(num_ways)) u_lru (
		.clk(clk),
		.arst_n(arst_n),
		.touch(touch),
		.touch_way(touch_way),
		.lru_way(lru_way)
	);

	vc_control #(.num_ways(num_ways)) u_control (
		.clk(clk),
		.arst_n(arst_n),
		.lookup(lookup),
		.lru_way(lru_way),
		.sel_valid(sel_valid),
		.sel_dirty(sel_dirty),
		.pmem_resp(pmem_resp),
		.ctrl(ctrl),
		.touch(touch),
		.touch_way(touch_way),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.resp(resp)
	);

	vc_datapath u_datapath (
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.sel_tag(sel_tag),
		.sel_data(sel_data),
		.sel_dirty(sel_dirty),
		.req_tag(lookup.req_tag),
		.pmem_rdata(pmem_rdata),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.rdata(rdata),
		.rdata_dirty(rdata_dirty)
	);

	assign l2_resp = '{resp: resp, rdata: rdata, dirty: rdata_dirty};

endmodule : victim_cache

/* verification/vc_checker.sv */
`timescale 1ns/1ps

module vc_checker
	import vc_types_pkg::*;
#(
	parameter int num_ways = 4
) (
	input logic clk,
	input logic arst_n,
	input vc_l2_req_t l2_req,
	input vc_l2_resp_t l2_resp,
	input logic pmem_read,
	input logic pmem_write,
	input vc_addr_t pmem_address,
	input vc_line_t pmem_wdata,
	input logic pmem_resp,
	output int error_count,
	output int resp_count,
	output int hit_count,
	output int miss_count,
	output int wb_count
);

	vc_tag_t model_tag [num_ways];
	vc_line_t model_data [num_ways];
	logic model_dirty [num_ways];
	logic model_valid [num_ways];
	// front of the queue is the oldest way
	int lru_order [$];

	logic pending;
	logic exp_hit;
	logic exp_wb;
	int exp_way;
	int cycle;
	int req_cycle;
	int reads_seen;
	int writes_seen;
	vc_addr_t req_line;
	vc_tag_t victim_tag;
	vc_line_t victim_data;
	logic victim_dirty;

	function automatic vc_line_t expected_fill(input vc_addr_t addr);
		vc_line_t line;
		line = '0;
		for (int i = 0; i < 8; i++) begin
			line[i*16 +: 16] = (addr * 16'h9e37) ^ (16'h3c5a + 16'(i) * 16'h1111)
				^ {addr[7:0], addr[15:8]};
		end
		return line;
	endfunction

	task automatic flag_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		error_count++;
	endtask

	function automatic int find_way(input vc_tag_t tag);
		int found;
		found = -1;
		for (int i = 0; i < num_ways; i++) begin
			if (model_valid[i] && model_tag[i] == tag) begin
				found = i;
			end
		end
		return found;
	endfunction

	task automatic make_youngest(input int way);
		for (int i = 0; i < lru_order.size(); i++) begin
			if (lru_order[i] == way) begin
				lru_order.delete(i);
				break;
			end
		end
		lru_order.push_back(way);
	endtask

	task automatic capture_request();
		int way;
		req_line = {l2_req.req_addr[15:4], 4'h0};
		victim_tag = l2_req.victim_addr[15:4];
		victim_data = l2_req.victim_data;
		victim_dirty = l2_req.victim_dirty;
		way = find_way(l2_req.req_addr[15:4]);
		pending = 1'b1;
		req_cycle = cycle;
		reads_seen = 0;
		writes_seen = 0;
		exp_hit = (way >= 0);
		exp_way = exp_hit ? way : lru_order[0];
		// only a miss evicts, and only a dirty valid line goes to memory
		exp_wb = !exp_hit && model_valid[exp_way] && model_dirty[exp_way];
	endtask

	task automatic check_write();
		writes_seen++;
		if (!pending || !exp_wb || writes_seen > 1) begin
			flag_error($sformatf("unexpected memory write to %h", pmem_address));
		end else begin
			if (pmem_address != {model_tag[exp_way], 4'h0}) begin
				flag_error($sformatf("writeback address %h, expected %h", pmem_address,
					{model_tag[exp_way], 4'h0}));
			end
			if (pmem_wdata != model_data[exp_way]) begin
				flag_error($sformatf("writeback data %h, expected %h", pmem_wdata,
					model_data[exp_way]));
			end
		end
	endtask

	task automatic check_read();
		reads_seen++;
		if (!pending || exp_hit || reads_seen > 1) begin
			flag_error($sformatf("unexpected memory read of %h", pmem_address));
		end else begin
			if (pmem_address != req_line) begin
				flag_error($sformatf("fetch address %h, expected %h", pmem_address, req_line));
			end
			if (exp_wb && writes_seen == 0) begin
				flag_error("fetch issued before the dirty line was written back");
			end
		end
	endtask

	task automatic check_response();
		if (!pending) begin
			flag_error("response with no request in flight");
		end else begin
			resp_count++;
			if (exp_hit) begin
				hit_count++;
				if (cycle - req_cycle != 3) begin
					flag_error($sformatf("hit answered after %0d cycles", cycle - req_cycle));
				end
				if (l2_resp.rdata != model_data[exp_way] ||
					l2_resp.dirty != model_dirty[exp_way]) begin
					flag_error($sformatf("hit data %h dirty %b, expected %h dirty %b",
						l2_resp.rdata, l2_resp.dirty, model_data[exp_way],
						model_dirty[exp_way]));
				end
			end else begin
				miss_count++;
				if (exp_wb) begin
					wb_count++;
				end
				if (l2_resp.rdata != expected_fill(req_line) || l2_resp.dirty) begin
					flag_error($sformatf("miss data %h dirty %b for line %h",
						l2_resp.rdata, l2_resp.dirty, req_line));
				end
				if (reads_seen != 1 || writes_seen != (exp_wb ? 1 : 0)) begin
					flag_error($sformatf("miss saw %0d reads and %0d writes",
						reads_seen, writes_seen));
				end
			end
			// victim takes over the hit way or the evicted one
			model_tag[exp_way] = victim_tag;
			model_data[exp_way] = victim_data;
			model_dirty[exp_way] = victim_dirty;
			model_valid[exp_way] = 1'b1;
			make_youngest(exp_way);
			pending = 1'b0;
		end
	endtask

	initial begin
		error_count = 0;
		resp_count = 0;
		hit_count = 0;
		miss_count = 0;
		wb_count = 0;
		pending = 1'b0;
	end

	always @(posedge clk) begin
		if (!arst_n) begin
			lru_order.delete();
			for (int i = 0; i < num_ways; i++) begin
				model_valid[i] = 1'b0;
				lru_order.push_back(i);
			end
			pending = 1'b0;
			cycle = 0;
			if (l2_resp.resp || pmem_read || pmem_write) begin
				flag_error("response or memory access active during reset");
			end
		end else begin
			cycle++;
			if (l2_req.req) begin
				capture_request();
			end
			if (pmem_resp && pmem_write) begin
				check_write();
			end
			if (pmem_resp && pmem_read) begin
				check_read();
			end
			if (l2_resp.resp) begin
				check_response();
			end
		end
	end

endmodule : vc_checker

/* verification/tb_victim_cache.sv */
`timescale 1ns/1ps

module tb_victim_cache
	import vc_types_pkg::*;
();

	localparam int num_ways = 4;
	localparam int clk_period = 10;
	localparam int num_reqs = 400;
	localparam int pool_size = 12;
	localparam int timeout_cycles = num_reqs * 20 + 16;

	logic clk;
	logic arst_n;
	vc_l2_req_t l2_req;
	vc_l2_resp_t l2_resp;
	logic pmem_read;
	logic pmem_write;
	vc_addr_t pmem_address;
	vc_line_t pmem_wdata;
	logic pmem_resp;
	vc_line_t pmem_rdata;

	int error_count;
	int resp_count;
	int hit_count;
	int miss_count;
	int wb_count;

	logic [31:0] rng = 32'h16ce;
	// set for tags that L2 currently holds
	bit in_l2 [pool_size];

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic vc_tag_t pool_tag(input int idx);
		return 12'h0a5 + 12'(idx) * 12'h13b;
	endfunction

	// memory contents as a hash of the line address
	function automatic vc_line_t memory_line(input vc_addr_t addr);
		vc_line_t line;
		line = '0;
		for (int i = 0; i < 8; i++) begin
			line[i*16 +: 16] = (addr * 16'h9e37) ^ (16'h3c5a + 16'(i) * 16'h1111)
				^ {addr[7:0], addr[15:8]};
		end
		return line;
	endfunction

	task automatic pick_tag(input bit from_l2, output int idx);
		int cand [$];
		for (int i = 0; i < pool_size; i++) begin
			if (in_l2[i] == from_l2) begin
				cand.push_back(i);
			end
		end
		rng = xorshift32(rng);
		idx = cand[rng % cand.size()];
	endtask

	task automatic random_line(output vc_line_t line);
		for (int i = 0; i < 4; i++) begin
			rng = xorshift32(rng);
			line[i*32 +: 32] = rng;
		end
	endtask

	victim_cache #(.num_ways(num_ways)) DUT (
		.clk(clk),
		.arst_n(arst_n),
		.l2_req(l2_req),
		.l2_resp(l2_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata)
	);

	vc_checker #(.num_ways(num_ways)) u_checker (
		.clk(clk),
		.arst_n(arst_n),
		.l2_req(l2_req),
		.l2_resp(l2_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.error_count(error_count),
		.resp_count(resp_count),
		.hit_count(hit_count),
		.miss_count(miss_count),
		.wb_count(wb_count)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// memory answers each access after 1 to 4 cycles
	initial begin
		int delay;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever begin
			@(posedge clk);
			if (arst_n && (pmem_read || pmem_write)) begin
				rng = xorshift32(rng);
				delay = 1 + int'(rng % 4);
				repeat (delay - 1) @(posedge clk);
				#1;
				pmem_resp = 1'b1;
				pmem_rdata = pmem_read ? memory_line(pmem_address) : '0;
				@(posedge clk);
				#1;
				pmem_resp = 1'b0;
				pmem_rdata = '0;
			end
		end
	end

	initial begin
		int req_idx;
		int vic_idx;
		vc_line_t vdata;
		arst_n = 1'b0;
		l2_req = '0;
		for (int i = 0; i < pool_size; i++) begin
			in_l2[i] = (i < pool_size / 2);
		end
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		for (int n = 0; n < num_reqs; n++) begin
			pick_tag(1'b0, req_idx);
			pick_tag(1'b1, vic_idx);
			random_line(vdata);
			rng = xorshift32(rng);
			l2_req.req_addr = {pool_tag(req_idx), rng[3:0]};
			l2_req.victim_addr = {pool_tag(vic_idx), rng[7:4]};
			l2_req.victim_data = vdata;
			l2_req.victim_dirty = rng[8];
			l2_req.req = 1'b1;
			// swap keeps L2 and the victim cache exclusive
			in_l2[req_idx] = 1'b1;
			in_l2[vic_idx] = 1'b0;
			@(posedge clk);
			#1;
			l2_req.req = 1'b0;
			do begin
				@(posedge clk);
			end while (!l2_resp.resp);
			#1;
		end
		repeat (4) @(posedge clk);
		if (resp_count != num_reqs) begin
			$display("only %0d of %0d requests got a response", resp_count, num_reqs);
		end
		$display("errors %0d, responses %0d, hits %0d, misses %0d, writebacks %0d",
			error_count, resp_count, hit_count, miss_count, wb_count);
		if (error_count == 0 && resp_count == num_reqs) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(timeout_cycles * clk_period);
		$display("watchdog expired after %0d cycles with %0d responses", timeout_cycles,
			resp_count);
		$display("Simulation failed");
		$finish;
	end

endmodule : tb_victim_cache

/* filelist.f */
common/vc_types_pkg.sv
common/vc_ctrl_pkg.sv
src/vc_lookup.sv
victim_store/vc_store.sv
victim_store/vc_lru.sv
src/vc_control.sv
src/vc_datapath.sv
src/victim_cache.sv
verification/vc_checker.sv
verification/tb_victim_cache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS = --timing --assert -Wno-fatal
TOP = tb_victim_cache
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
